//--- source/procyon_settings.svh
`ifndef PROCYON_SETTINGS_SVH
`define PROCYON_SETTINGS_SVH

// Datapath and register file
`define DATA_WIDTH 32
`define REG_COUNT  32

// Execution lanes with one CDB slot each
`define LANE_COUNT 2
`define RS_DEPTH   2

// Reorder buffer
// TAG_WIDTH is log2 of ROB_DEPTH
`define ROB_DEPTH  8
`define TAG_WIDTH  3

`endif

//--- source/procyon_pkg.sv
`include "procyon_settings.svh"

package procyon_pkg;

    typedef logic [`DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [4:0]             procyon_reg_t;
    typedef logic [`TAG_WIDTH-1:0]  procyon_tag_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100
    } procyon_alu_op_t;

    typedef struct packed {
        logic [6:0]   funct7;
        procyon_reg_t rs2;
        procyon_reg_t rs1;
        logic [2:0]   funct3;
        procyon_reg_t rd;
        logic [6:0]   opcode;
    } procyon_r_insn_t;

    typedef struct packed {
        logic [11:0]  imm;
        procyon_reg_t rs1;
        logic [2:0]   funct3;
        procyon_reg_t rd;
        logic [6:0]   opcode;
    } procyon_i_insn_t;

    // One instruction word read through either layout
    typedef union packed {
        procyon_r_insn_t r;
        procyon_i_insn_t i;
    } procyon_insn_t;

endpackage

//--- source/procyon_dispatch.sv
`timescale 1ns/1ns
`include "procyon_settings.svh"

module procyon_dispatch (
    input  logic                          clk,
    input  logic                          i_rst_n,

    input  logic                          i_insn_valid,
    input  procyon_pkg::procyon_insn_t    i_insn,
    output logic                          o_dispatch_stall,

    input  logic                          i_rob_full,
    input  procyon_pkg::procyon_tag_t     i_rob_alloc_tag,
    input  logic                          i_rs_full         [0:`LANE_COUNT-1],

    input  logic                          i_regmap_rdy      [0:1],
    input  procyon_pkg::procyon_data_t    i_regmap_data     [0:1],
    input  procyon_pkg::procyon_tag_t     i_regmap_tag      [0:1],
    input  logic                          i_rob_lookup_done [0:1],
    input  procyon_pkg::procyon_data_t    i_rob_lookup_data [0:1],

    input  logic                          i_cdb_en          [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_tag_t     i_cdb_tag         [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_data_t    i_cdb_data        [0:`LANE_COUNT-1],

    output procyon_pkg::procyon_reg_t     o_regmap_rsrc     [0:1],
    output logic                          o_rename_en,
    output procyon_pkg::procyon_reg_t     o_rename_rdest,
    output logic                          o_rob_enq_en,
    output procyon_pkg::procyon_reg_t     o_rob_enq_rdest,
    output procyon_pkg::procyon_tag_t     o_rob_lookup_tag  [0:1],

    output logic                          o_rs_en           [0:`LANE_COUNT-1],
    output procyon_pkg::procyon_alu_op_t  o_rs_op,
    output procyon_pkg::procyon_data_t    o_rs_src_data     [0:1],
    output logic                          o_rs_src_rdy      [0:1],
    output procyon_pkg::procyon_tag_t     o_rs_src_tag      [0:1],
    output procyon_pkg::procyon_tag_t     o_rs_dst_tag
);

    localparam logic [6:0] OPCODE_OP = 7'b0110011;

    logic                       is_rtype;
    logic                       accept;
    logic                       stall_now;
    logic                       stall_q;
    logic                       none_free;
    logic                       pick [0:`LANE_COUNT-1];
    procyon_pkg::procyon_data_t imm_data;

    // Anything that is not OP is OP-IMM here
    assign is_rtype = (i_insn.r.opcode == OPCODE_OP);
    assign imm_data = {{(`DATA_WIDTH-12){i_insn.i.imm[11]}}, i_insn.i.imm};

    always_comb begin
        case (i_insn.r.funct3)
            3'b000: begin
                if (is_rtype && i_insn.r.funct7[5]) begin
                    o_rs_op = procyon_pkg::ALU_SUB;
                end else begin
                    o_rs_op = procyon_pkg::ALU_ADD;
                end
            end
            3'b100:  o_rs_op = procyon_pkg::ALU_XOR;
            3'b110:  o_rs_op = procyon_pkg::ALU_OR;
            3'b111:  o_rs_op = procyon_pkg::ALU_AND;
            default: o_rs_op = procyon_pkg::ALU_ADD;
        endcase
    end

    assign o_regmap_rsrc[0] = i_insn.r.rs1;
    assign o_regmap_rsrc[1] = i_insn.r.rs2;

    // Operand from regmap, then a done ROB entry, then this cycle's CDB
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_rob_lookup_tag[s] = i_regmap_tag[s];
            o_rs_src_tag[s]     = i_regmap_tag[s];
            o_rs_src_rdy[s]     = i_regmap_rdy[s];
            o_rs_src_data[s]    = i_regmap_data[s];
            if (!i_regmap_rdy[s]) begin
                if (i_rob_lookup_done[s]) begin
                    o_rs_src_rdy[s]  = 1'b1;
                    o_rs_src_data[s] = i_rob_lookup_data[s];
                end
                for (int k = 0; k < `LANE_COUNT; k++) begin
                    if (i_cdb_en[k] && (i_cdb_tag[k] == i_regmap_tag[s])) begin
                        o_rs_src_rdy[s]  = 1'b1;
                        o_rs_src_data[s] = i_cdb_data[k];
                    end
                end
            end
        end
        if (!is_rtype) begin
            o_rs_src_rdy[1]  = 1'b1;
            o_rs_src_data[1] = imm_data;
        end
    end

    // Lowest-numbered lane with a free slot
    always_comb begin
        none_free = 1'b1;
        for (int k = 0; k < `LANE_COUNT; k++) begin
            pick[k] = none_free && !i_rs_full[k];
            if (!i_rs_full[k]) begin
                none_free = 1'b0;
            end
        end
    end

    assign stall_now        = i_rob_full || none_free;
    assign o_dispatch_stall = stall_now || stall_q;
    assign accept           = i_insn_valid && !o_dispatch_stall;

    // Stall is held one cycle past the full condition
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_now;
        end
    end

    always_comb begin
        for (int k = 0; k < `LANE_COUNT; k++) begin
            o_rs_en[k] = accept && pick[k];
        end
    end

    assign o_rename_en     = accept;
    assign o_rename_rdest  = i_insn.r.rd;
    assign o_rob_enq_en    = accept;
    assign o_rob_enq_rdest = i_insn.r.rd;
    assign o_rs_dst_tag    = i_rob_alloc_tag;

endmodule

//--- source/procyon_register_map.sv
`timescale 1ns/1ns
`include "procyon_settings.svh"

module procyon_register_map (
    input  logic                        clk,
    input  logic                        i_rst_n,

    input  procyon_pkg::procyon_reg_t   i_lookup_rsrc  [0:1],
    output logic                        o_lookup_rdy   [0:1],
    output procyon_pkg::procyon_data_t  o_lookup_data  [0:1],
    output procyon_pkg::procyon_tag_t   o_lookup_tag   [0:1],

    input  logic                        i_rename_en,
    input  procyon_pkg::procyon_reg_t   i_rename_rdest,
    input  procyon_pkg::procyon_tag_t   i_rename_tag,

    input  logic                        i_retire_en,
    input  procyon_pkg::procyon_reg_t   i_retire_rdest,
    input  procyon_pkg::procyon_tag_t   i_retire_tag,
    input  procyon_pkg::procyon_data_t  i_retire_data
);

    procyon_pkg::procyon_data_t regs    [0:`REG_COUNT-1];
    logic                       pending [0:`REG_COUNT-1];
    procyon_pkg::procyon_tag_t  tags    [0:`REG_COUNT-1];

    // x0 reads as a ready zero
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_lookup_rdy[s]  = (i_lookup_rsrc[s] == '0) || !pending[i_lookup_rsrc[s]];
            o_lookup_data[s] = (i_lookup_rsrc[s] == '0) ? '0 : regs[i_lookup_rsrc[s]];
            o_lookup_tag[s]  = tags[i_lookup_rsrc[s]];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r]    <= '0;
                pending[r] <= 1'b0;
                tags[r]    <= '0;
            end
        end else begin
            if (i_retire_en && (i_retire_rdest != '0)) begin
                regs[i_retire_rdest] <= i_retire_data;
                // Younger rename keeps the register pending
                if (tags[i_retire_rdest] == i_retire_tag) begin
                    pending[i_retire_rdest] <= 1'b0;
                end
            end
            if (i_rename_en && (i_rename_rdest != '0)) begin
                pending[i_rename_rdest] <= 1'b1;
                tags[i_rename_rdest]    <= i_rename_tag;
            end
        end
    end

endmodule

//--- source/procyon_lane.sv
`timescale 1ns/1ns
`include "procyon_settings.svh"

module procyon_lane (
    input  logic                          clk,
    input  logic                          i_rst_n,

    input  logic                          i_rs_en,
    input  procyon_pkg::procyon_alu_op_t  i_rs_op,
    input  procyon_pkg::procyon_data_t    i_rs_src_data [0:1],
    input  logic                          i_rs_src_rdy  [0:1],
    input  procyon_pkg::procyon_tag_t     i_rs_src_tag  [0:1],
    input  procyon_pkg::procyon_tag_t     i_rs_dst_tag,
    output logic                          o_rs_full,

    input  logic                          i_cdb_en      [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_tag_t     i_cdb_tag     [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_data_t    i_cdb_data    [0:`LANE_COUNT-1],

    output logic                          o_cdb_en,
    output procyon_pkg::procyon_tag_t     o_cdb_tag,
    output procyon_pkg::procyon_data_t    o_cdb_data
);

    localparam int IDX_W = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

    logic                         slot_valid [0:`RS_DEPTH-1];
    procyon_pkg::procyon_alu_op_t slot_op    [0:`RS_DEPTH-1];
    procyon_pkg::procyon_data_t   slot_data  [0:`RS_DEPTH-1][0:1];
    logic                         slot_rdy   [0:`RS_DEPTH-1][0:1];
    procyon_pkg::procyon_tag_t    slot_tag   [0:`RS_DEPTH-1][0:1];
    procyon_pkg::procyon_tag_t    slot_dst   [0:`RS_DEPTH-1];

    logic                         issue_en;
    logic [IDX_W-1:0]             issue_idx;
    logic [IDX_W-1:0]             alloc_idx;
    procyon_pkg::procyon_data_t   alu_a;
    procyon_pkg::procyon_data_t   alu_b;
    procyon_pkg::procyon_data_t   alu_result;

    // Descending scan leaves the lowest index selected
    always_comb begin
        o_rs_full = 1'b1;
        issue_en  = 1'b0;
        issue_idx = '0;
        alloc_idx = '0;
        for (int i = `RS_DEPTH-1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                o_rs_full = 1'b0;
                alloc_idx = IDX_W'(i);
            end
            if (slot_valid[i] && slot_rdy[i][0] && slot_rdy[i][1]) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign alu_a = slot_data[issue_idx][0];
    assign alu_b = slot_data[issue_idx][1];

    always_comb begin
        case (slot_op[issue_idx])
            procyon_pkg::ALU_SUB: alu_result = alu_a - alu_b;
            procyon_pkg::ALU_AND: alu_result = alu_a & alu_b;
            procyon_pkg::ALU_OR:  alu_result = alu_a | alu_b;
            procyon_pkg::ALU_XOR: alu_result = alu_a ^ alu_b;
            default:              alu_result = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                slot_valid[i] <= 1'b0;
            end
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= issue_en;
            if (issue_en) begin
                slot_valid[issue_idx] <= 1'b0;
            end
            if (i_rs_en) begin
                slot_valid[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Wakeup on any CDB slot carrying a waited-for tag
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < `LANE_COUNT; k++) begin
                    if (!slot_rdy[i][s] && i_cdb_en[k] && (i_cdb_tag[k] == slot_tag[i][s])) begin
                        slot_rdy[i][s]  <= 1'b1;
                        slot_data[i][s] <= i_cdb_data[k];
                    end
                end
            end
        end
        if (i_rs_en) begin
            slot_op[alloc_idx]  <= i_rs_op;
            slot_dst[alloc_idx] <= i_rs_dst_tag;
            for (int s = 0; s < 2; s++) begin
                slot_data[alloc_idx][s] <= i_rs_src_data[s];
                slot_rdy[alloc_idx][s]  <= i_rs_src_rdy[s];
                slot_tag[alloc_idx][s]  <= i_rs_src_tag[s];
            end
        end
        o_cdb_tag  <= slot_dst[issue_idx];
        o_cdb_data <= alu_result;
    end

endmodule

//--- source/procyon_reorder_buffer.sv
`timescale 1ns/1ns
`include "procyon_settings.svh"

module procyon_reorder_buffer (
    input  logic                        clk,
    input  logic                        i_rst_n,

    input  logic                        i_enq_en,
    input  procyon_pkg::procyon_reg_t   i_enq_rdest,
    output logic                        o_full,
    output procyon_pkg::procyon_tag_t   o_alloc_tag,

    input  procyon_pkg::procyon_tag_t   i_lookup_tag  [0:1],
    output logic                        o_lookup_done [0:1],
    output procyon_pkg::procyon_data_t  o_lookup_data [0:1],

    input  logic                        i_cdb_en      [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_tag_t   i_cdb_tag     [0:`LANE_COUNT-1],
    input  procyon_pkg::procyon_data_t  i_cdb_data    [0:`LANE_COUNT-1],

    output logic                        o_retire_en,
    output procyon_pkg::procyon_reg_t   o_retire_rdest,
    output procyon_pkg::procyon_tag_t   o_retire_tag,
    output procyon_pkg::procyon_data_t  o_retire_data
);

    logic                       entry_done  [0:`ROB_DEPTH-1];
    procyon_pkg::procyon_reg_t  entry_rdest [0:`ROB_DEPTH-1];
    procyon_pkg::procyon_data_t entry_data  [0:`ROB_DEPTH-1];

    procyon_pkg::procyon_tag_t  head;
    procyon_pkg::procyon_tag_t  tail;
    logic [`TAG_WIDTH:0]        count;

    assign o_full      = (count == `ROB_DEPTH);
    assign o_alloc_tag = tail;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_lookup_done[s] = entry_done[i_lookup_tag[s]];
            o_lookup_data[s] = entry_data[i_lookup_tag[s]];
        end
    end

    // Head leaves in the cycle after its result was captured
    assign o_retire_en    = (count != '0) && entry_done[head];
    assign o_retire_rdest = entry_rdest[head];
    assign o_retire_tag   = head;
    assign o_retire_data  = entry_data[head];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_enq_en) begin
                tail <= tail + 1'b1;
            end
            if (o_retire_en) begin
                head <= head + 1'b1;
            end
            case ({i_enq_en, o_retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `LANE_COUNT; k++) begin
            if (i_cdb_en[k]) begin
                entry_done[i_cdb_tag[k]] <= 1'b1;
                entry_data[i_cdb_tag[k]] <= i_cdb_data[k];
            end
        end
        if (i_enq_en) begin
            entry_done[tail]  <= 1'b0;
            entry_rdest[tail] <= i_enq_rdest;
        end
    end

endmodule

//--- source/procyon_core.sv
`timescale 1ns/1ns
`include "procyon_settings.svh"

module procyon_core (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_insn_valid,
    input  procyon_pkg::procyon_insn_t  i_insn,
    output logic                        o_dispatch_stall,
    output logic                        o_retire_en,
    output procyon_pkg::procyon_reg_t   o_retire_rdest,
    output procyon_pkg::procyon_data_t  o_retire_data
);

    logic                         rob_full;
    procyon_pkg::procyon_tag_t    rob_alloc_tag;
    logic                         rob_enq_en;
    procyon_pkg::procyon_reg_t    rob_enq_rdest;
    procyon_pkg::procyon_tag_t    rob_lookup_tag  [0:1];
    logic                         rob_lookup_done [0:1];
    procyon_pkg::procyon_data_t   rob_lookup_data [0:1];
    procyon_pkg::procyon_tag_t    retire_tag;

    procyon_pkg::procyon_reg_t    regmap_rsrc     [0:1];
    logic                         regmap_rdy      [0:1];
    procyon_pkg::procyon_data_t   regmap_data     [0:1];
    procyon_pkg::procyon_tag_t    regmap_tag      [0:1];
    logic                         rename_en;
    procyon_pkg::procyon_reg_t    rename_rdest;

    logic                         rs_en           [0:`LANE_COUNT-1];
    logic                         rs_full         [0:`LANE_COUNT-1];
    procyon_pkg::procyon_alu_op_t rs_op;
    procyon_pkg::procyon_data_t   rs_src_data     [0:1];
    logic                         rs_src_rdy      [0:1];
    procyon_pkg::procyon_tag_t    rs_src_tag      [0:1];
    procyon_pkg::procyon_tag_t    rs_dst_tag;

    logic                         cdb_en          [0:`LANE_COUNT-1];
    procyon_pkg::procyon_tag_t    cdb_tag         [0:`LANE_COUNT-1];
    procyon_pkg::procyon_data_t   cdb_data        [0:`LANE_COUNT-1];

    procyon_dispatch dispatch0 (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_dispatch_stall(o_dispatch_stall),
        .i_rob_full(rob_full),
        .i_rob_alloc_tag(rob_alloc_tag),
        .i_rs_full(rs_full),
        .i_regmap_rdy(regmap_rdy),
        .i_regmap_data(regmap_data),
        .i_regmap_tag(regmap_tag),
        .i_rob_lookup_done(rob_lookup_done),
        .i_rob_lookup_data(rob_lookup_data),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .o_regmap_rsrc(regmap_rsrc),
        .o_rename_en(rename_en),
        .o_rename_rdest(rename_rdest),
        .o_rob_enq_en(rob_enq_en),
        .o_rob_enq_rdest(rob_enq_rdest),
        .o_rob_lookup_tag(rob_lookup_tag),
        .o_rs_en(rs_en),
        .o_rs_op(rs_op),
        .o_rs_src_data(rs_src_data),
        .o_rs_src_rdy(rs_src_rdy),
        .o_rs_src_tag(rs_src_tag),
        .o_rs_dst_tag(rs_dst_tag)
    );

    procyon_register_map register_map0 (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_lookup_rsrc(regmap_rsrc),
        .o_lookup_rdy(regmap_rdy),
        .o_lookup_data(regmap_data),
        .o_lookup_tag(regmap_tag),
        .i_rename_en(rename_en),
        .i_rename_rdest(rename_rdest),
        .i_rename_tag(rob_alloc_tag),
        .i_retire_en(o_retire_en),
        .i_retire_rdest(o_retire_rdest),
        .i_retire_tag(retire_tag),
        .i_retire_data(o_retire_data)
    );

    genvar k;
    generate
        for (k = 0; k < `LANE_COUNT; k++) begin : gen_lane
            procyon_lane lane0 (
                .clk(clk),
                .i_rst_n(i_rst_n),
                .i_rs_en(rs_en[k]),
                .i_rs_op(rs_op),
                .i_rs_src_data(rs_src_data),
                .i_rs_src_rdy(rs_src_rdy),
                .i_rs_src_tag(rs_src_tag),
                .i_rs_dst_tag(rs_dst_tag),
                .o_rs_full(rs_full[k]),
                .i_cdb_en(cdb_en),
                .i_cdb_tag(cdb_tag),
                .i_cdb_data(cdb_data),
                .o_cdb_en(cdb_en[k]),
                .o_cdb_tag(cdb_tag[k]),
                .o_cdb_data(cdb_data[k])
            );
        end
    endgenerate

    procyon_reorder_buffer reorder_buffer0 (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_enq_en(rob_enq_en),
        .i_enq_rdest(rob_enq_rdest),
        .o_full(rob_full),
        .o_alloc_tag(rob_alloc_tag),
        .i_lookup_tag(rob_lookup_tag),
        .o_lookup_done(rob_lookup_done),
        .o_lookup_data(rob_lookup_data),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .o_retire_en(o_retire_en),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_tag(retire_tag),
        .o_retire_data(o_retire_data)
    );

endmodule

//--- dv/procyon_tb.sv
`timescale 1ns/1ns

module procyon_tb;

    localparam int BURST_LEN    = 11;
    localparam int STALL_LIMIT  = 100;
    localparam int RETIRE_LIMIT = 300;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_insn_valid;
    procyon_pkg::procyon_insn_t i_insn;
    logic                       o_dispatch_stall;
    logic                       o_retire_en;
    procyon_pkg::procyon_reg_t  o_retire_rdest;
    procyon_pkg::procyon_data_t o_retire_data;

    logic [31:0] insn_q  [$];
    logic [31:0] rdest_q [$];
    logic [31:0] data_q  [$];
    int          accepted;
    int          retired;
    logic        stall_seen;
    integer      seed;

    procyon_core dut0 (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_dispatch_stall(o_dispatch_stall),
        .o_retire_en(o_retire_en),
        .o_retire_rdest(o_retire_rdest),
        .o_retire_data(o_retire_data)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED: %s is 0x%08h, expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    task automatic load_testdata();
        integer      fd;
        integer      code;
        integer      ch;
        logic [31:0] word;
        logic [31:0] rdest;
        logic [31:0] value;
        fd = $fopen("dv/procyon_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open dv/procyon_testdata.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%h %h %h", word, rdest, value);
            if (code == 3) begin
                insn_q.push_back(word);
                rdest_q.push_back(rdest);
                data_q.push_back(value);
            end else if (code == 1 || code == 2) begin
                stop_with_failure("malformed line in the data file");
            end else begin
                // Comment line, skip to its end
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end
        end
        $fclose(fd);
        if (insn_q.size() == 0) begin
            stop_with_failure("no instructions found in the data file");
        end
    endtask

    // Retire stream in program order
    always @(negedge clk) begin
        if (i_rst_n === 1'b1 && o_retire_en === 1'b1) begin
            if (accepted == 0) begin
                stop_with_failure("retirement seen before any instruction was accepted");
            end else if (retired >= insn_q.size()) begin
                stop_with_failure("more retirements than lines in the data file");
            end else begin
                check_value("o_retire_rdest", 32'(o_retire_rdest), rdest_q[retired]);
                check_value("o_retire_data", o_retire_data, data_q[retired]);
                retired++;
            end
        end
    end

    initial begin
        int gap;
        int waited;
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_insn_valid = 1'b0;
        i_insn       = '0;
        accepted     = 0;
        retired      = 0;
        stall_seen   = 1'b0;
        seed         = 32'he8a4_d3c6;
        load_testdata();

        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_value("o_retire_en", 32'(o_retire_en), 32'h0);
        check_value("o_dispatch_stall", 32'(o_dispatch_stall), 32'h0);
        @(posedge clk);

        for (int n = 0; n < insn_q.size(); n++) begin
            gap = $unsigned($random(seed)) % 4;
            // Tail of the file goes in back to back
            if (n >= insn_q.size() - BURST_LEN) begin
                gap = 0;
            end
            if (gap > 0) begin
                i_insn_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            i_insn_valid <= 1'b1;
            i_insn       <= insn_q[n];
            waited = 0;
            @(negedge clk);
            while (o_dispatch_stall) begin
                stall_seen = 1'b1;
                waited++;
                if (waited > STALL_LIMIT) begin
                    stop_with_failure("dispatch stall never cleared");
                end
                @(negedge clk);
            end
            @(posedge clk);
            accepted++;
        end
        i_insn_valid <= 1'b0;

        waited = 0;
        while (retired < insn_q.size()) begin
            waited++;
            if (waited > RETIRE_LIMIT) begin
                stop_with_failure("retire never arrived");
            end
            @(posedge clk);
        end
        // Quiet window to catch duplicate retirements
        repeat (10) @(posedge clk);
        check_value("o_dispatch_stall seen high", 32'(stall_seen), 32'h1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- dv/procyon_testdata.txt
# insn     rdest value      (all hex, one instruction per line)
# rdest and value are the expected retire outputs, registers start at zero
12300093 01 00000123
fff00113 02 ffffffff
5a506193 03 000005a5
0f00c213 04 000001d3
7f017293 05 000007f0
00308333 06 000006c8
403083b3 07 fffffb7e
00417433 08 000001d3
0051e4b3 09 000007f5
00734533 0a fffffdb6
7ff08013 00 00000922
001005b3 0b 00000123
10060613 0c 00000100
01160613 0c 00000111
00c606b3 0d 00000222
00168713 0e 00000223
0ff74713 0e 000002dc
00e70733 0e 000005b8
40170733 0e 00000495
30076713 0e 00000795
6f677713 0e 00000694
00274733 0e fffff96b
01070713 0e fffff97b
006777b3 0f 00000048
00e7e833 10 fffff97b
40f808b3 11 fffff933

//--- sim.f
+incdir+source
source/procyon_pkg.sv
source/procyon_dispatch.sv
source/procyon_register_map.sv
source/procyon_lane.sv
source/procyon_reorder_buffer.sv
source/procyon_core.sv
dv/procyon_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := procyon_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
